/* include/ldu_consts.svh */
`ifndef LDU_CONSTS_SVH
`define LDU_CONSTS_SVH

// Number of ROB slots
// At most depth minus one loads are in flight
`define LDU_ROB_DEPTH 4

// Data word width in bits
`define LDU_DATA_W 32

// Byte address width
// Bit 2 picks the bank, bits above it pick the row
`define LDU_ADDR_W 8

// Bank 0 read latency in cycles
`define LDU_FAST_LAT 1

// Bank 1 read latency in cycles, also the reservation window length
`define LDU_SLOW_LAT 4

`endif

/* verilog/ldu_pkg.sv */
`default_nettype none

package ldu_pkg;

  `include "ldu_consts.svh"

  // ROB slot index
  typedef logic [$clog2(`LDU_ROB_DEPTH)-1:0] rob_id_t;

  // Access size
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } ld_size_e;

  // External load request
  typedef struct packed {
    logic [`LDU_ADDR_W-1:0] addr;
    ld_size_e               size;
    logic                   sign;
  } ld_req_t;

  // Formatting info carried along with each load
  typedef struct packed {
    logic [1:0] offset;
    ld_size_e   size;
    logic       sign;
  } ld_meta_t;

  // Bank request, waddr is the row inside the selected bank
  typedef struct packed {
    logic [`LDU_ADDR_W-4:0] waddr;
    logic                   bank;
    rob_id_t                id;
    ld_meta_t               meta;
  } mem_req_t;

  // Bank response
  typedef struct packed {
    rob_id_t                id;
    logic [`LDU_DATA_W-1:0] word;
    ld_meta_t               meta;
  } mem_rsp_t;

  // ROB slot contents
  typedef struct packed {
    logic [`LDU_DATA_W-1:0] word;
    ld_meta_t               meta;
  } rob_entry_t;

  // Final load result
  typedef struct packed {
    logic [`LDU_DATA_W-1:0] data;
  } ld_rsp_t;

endpackage

`default_nettype wire

/* verilog/ld_issue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ldu_consts.svh"

module ld_issue import ldu_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire ld_req_t  req_i,
  input  wire logic     req_valid_i,
  output logic          req_ready_o,
  input  wire logic     rob_full_i,
  output logic          rob_id_req_o,
  input  wire rob_id_t  rob_id_i,
  output mem_req_t      mem_req_o,
  output logic          mem_req_valid_o
);

  localparam int unsigned FastLat = `LDU_FAST_LAT;
  localparam int unsigned SlowLat = `LDU_SLOW_LAT;

  // Bit i set means a bank response lands on the ROB port i+1 cycles from now
  logic [SlowLat-1:0] resv_q;
  logic [SlowLat-1:0] resv_shift;
  logic [SlowLat-1:0] resv_n;

  logic     run_q;
  logic     bank;
  logic     slot_busy;
  logic     accept;
  mem_req_t mem_req_q;
  logic     mem_req_valid_q;

  // Even words in bank 0, odd words in bank 1
  assign bank = req_i.addr[2];

  // Window as seen one cycle later, when the request reaches the bank
  assign resv_shift = resv_q >> 1;

  // Return cycle of this load already claimed by an older one
  assign slot_busy = bank ? resv_shift[SlowLat-1] : resv_shift[FastLat-1];

  assign req_ready_o  = run_q && !rob_full_i && !slot_busy;
  assign accept       = req_valid_i && req_ready_o;
  assign rob_id_req_o = accept;

  // Advance window and claim the return cycle of the new load
  always_comb begin
    resv_n = resv_shift;
    if (accept) begin
      if (bank) begin
        resv_n[SlowLat-1] = 1'b1;
      end else begin
        resv_n[FastLat-1] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resv_q          <= '0;
      run_q           <= 1'b0;
      mem_req_valid_q <= 1'b0;
    end else begin
      resv_q          <= resv_n;
      // Open for requests from the first edge after reset
      run_q           <= 1'b1;
      mem_req_valid_q <= accept;
    end
  end

  // Bank request tagged with its ROB slot and format info
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_req_q.waddr       <= req_i.addr[`LDU_ADDR_W-1:3];
      mem_req_q.bank        <= bank;
      mem_req_q.id          <= rob_id_i;
      mem_req_q.meta.offset <= req_i.addr[1:0];
      mem_req_q.meta.size   <= req_i.size;
      mem_req_q.meta.sign   <= req_i.sign;
    end
  end

  assign mem_req_o       = mem_req_q;
  assign mem_req_valid_o = mem_req_valid_q;

endmodule

`default_nettype wire

/* verilog/mem_banks.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ldu_consts.svh"

module mem_banks import ldu_pkg::*; (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire mem_req_t               mem_req_i,
  input  wire logic                   mem_req_valid_i,
  input  wire logic                   wr_en_i,
  input  wire logic [`LDU_ADDR_W-3:0] wr_addr_i,
  input  wire logic [`LDU_DATA_W-1:0] wr_data_i,
  output mem_rsp_t                    mem_rsp_o,
  output logic                        mem_rsp_valid_o
);

  localparam int unsigned AddrW = `LDU_ADDR_W;
  localparam int unsigned DataW = `LDU_DATA_W;
  // Rows per bank
  localparam int unsigned Rows  = 2 ** (AddrW - 3);

  // Last pipeline stage of each bank
  mem_rsp_t [1:0] bank_rsp;
  logic     [1:0] bank_valid;

  for (genvar b = 0; b < 2; b++) begin : g_bank
    localparam int unsigned Lat = (b == 0) ? `LDU_FAST_LAT : `LDU_SLOW_LAT;

    logic [DataW-1:0] mem_q [Rows];
    mem_rsp_t [Lat-1:0] pipe_q;
    logic     [Lat-1:0] pipe_valid_q;
    logic               hit;

    assign hit = mem_req_valid_i && (mem_req_i.bank == 1'(b));

    // Write port, low bit of the word address picks the bank
    always_ff @(posedge clk_i) begin
      if (wr_en_i && (wr_addr_i[0] == 1'(b))) begin
        mem_q[wr_addr_i[AddrW-3:1]] <= wr_data_i;
      end
    end

    // Read in stage 0, then walk the word down the pipe
    always_ff @(posedge clk_i) begin
      if (hit) begin
        pipe_q[0].id   <= mem_req_i.id;
        pipe_q[0].word <= mem_q[mem_req_i.waddr];
        pipe_q[0].meta <= mem_req_i.meta;
      end
      for (int i = 1; i < Lat; i++) begin
        pipe_q[i] <= pipe_q[i-1];
      end
    end

    // Several loads may be in flight per bank
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        pipe_valid_q <= '0;
      end else begin
        pipe_valid_q[0] <= hit;
        for (int i = 1; i < Lat; i++) begin
          pipe_valid_q[i] <= pipe_valid_q[i-1];
        end
      end
    end

    assign bank_rsp[b]   = pipe_q[Lat-1];
    assign bank_valid[b] = pipe_valid_q[Lat-1];
  end

  // Single response port, issue scheduling keeps the banks apart
  assign mem_rsp_valid_o = |bank_valid;
  assign mem_rsp_o       = bank_valid[1] ? bank_rsp[1] : bank_rsp[0];

  // Return slot reservation in the issue stage must prevent this
  bank_collision : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(bank_valid[0] && bank_valid[1]))
  else $error("Both banks returned a word in the same cycle");

endmodule

`default_nettype wire

/* verilog/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ldu_consts.svh"

module reorder_buffer import ldu_pkg::*; #(
  parameter bit FallThrough = 1'b0
) (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Write side, indexed by ID
  input  wire rob_entry_t data_i,
  input  wire rob_id_t    id_i,
  input  wire logic       push_i,
  // Read side, in order
  output rob_entry_t      data_o,
  output logic            valid_o,
  input  wire logic       pop_i,
  // ID allocation
  input  wire logic       id_req_i,
  output rob_id_t         id_o,
  output logic            full_o
);

  localparam int unsigned Depth = `LDU_ROB_DEPTH;
  localparam int unsigned IdW   = $bits(rob_id_t);
  // Full one entry early
  localparam logic [IdW:0] FullCnt = (IdW + 1)'(Depth - 1);
  localparam rob_id_t      LastId  = IdW'(Depth - 1);

  rob_id_t          rd_ptr_q;
  rob_id_t          rd_ptr_n;
  rob_id_t          wr_ptr_q;
  rob_id_t          wr_ptr_n;
  // Allocated and not yet released
  logic [IdW:0]     cnt_q;
  logic [IdW:0]     cnt_n;
  logic [Depth-1:0] valid_q;
  logic [Depth-1:0] valid_n;
  rob_entry_t       mem_q [Depth];

  assign full_o = (cnt_q == FullCnt);
  // Next free slot
  assign id_o   = wr_ptr_q;

  always_comb begin
    rd_ptr_n = rd_ptr_q;
    wr_ptr_n = wr_ptr_q;
    cnt_n    = cnt_q;
    valid_n  = valid_q;

    // Head slot
    data_o  = mem_q[rd_ptr_q];
    valid_o = valid_q[rd_ptr_q];

    // Head word arriving right now skips the storage
    if (FallThrough && push_i && (id_i == rd_ptr_q)) begin
      data_o  = data_i;
      valid_o = 1'b1;
    end

    // Allocate
    if (id_req_i && !full_o) begin
      wr_ptr_n = (wr_ptr_q == LastId) ? '0 : wr_ptr_q + 1'b1;
      cnt_n    = cnt_n + 1'b1;
    end

    // Fill
    if (push_i) begin
      valid_n[id_i] = 1'b1;
    end

    // Release head, clears the bit just set on fall-through
    if (pop_i && valid_o) begin
      valid_n[rd_ptr_q] = 1'b0;
      rd_ptr_n          = (rd_ptr_q == LastId) ? '0 : rd_ptr_q + 1'b1;
      cnt_n             = cnt_n - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
      valid_q  <= '0;
    end else begin
      rd_ptr_q <= rd_ptr_n;
      wr_ptr_q <= wr_ptr_n;
      cnt_q    <= cnt_n;
      valid_q  <= valid_n;
    end
  end

  // Slot storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[id_i] <= data_i;
    end
  end

  // Issue stage must hold off while full
  full_id_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni) full_o |-> !id_req_i)
  else $error("ID requested while the ROB is full");

  // Consumer must only pop a valid head
  empty_pop : assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_i |-> valid_o)
  else $error("Pop of an invalid ROB head");

endmodule

`default_nettype wire

/* verilog/ld_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ldu_consts.svh"

module ld_align import ldu_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire rob_entry_t entry_i,
  input  wire logic       entry_valid_i,
  output logic            pop_o,
  output ld_rsp_t         rsp_o,
  output logic            rsp_valid_o
);

  localparam int unsigned DataW = `LDU_DATA_W;

  logic [DataW-1:0] shifted;
  logic [DataW-1:0] result;
  ld_rsp_t          rsp_q;
  logic             rsp_valid_q;

  // No back-pressure, take the head as soon as it shows up
  assign pop_o = entry_valid_i;

  // Addressed field down to bit 0
  assign shifted = entry_i.word >> {entry_i.meta.offset, 3'b000};

  // Mask to size and extend
  always_comb begin
    case (entry_i.meta.size)
      size_byte: begin
        result = {{(DataW-8){entry_i.meta.sign & shifted[7]}}, shifted[7:0]};
      end
      size_half: begin
        result = {{(DataW-16){entry_i.meta.sign & shifted[15]}}, shifted[15:0]};
      end
      default: begin
        result = shifted;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= entry_valid_i;
    end
  end

  // Result payload
  always_ff @(posedge clk_i) begin
    if (entry_valid_i) begin
      rsp_q.data <= result;
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

  // Requests are expected naturally aligned
  half_aligned : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (entry_valid_i && entry_i.meta.size == size_half) |-> !entry_i.meta.offset[0])
  else $error("Halfword load at an odd byte offset");

  word_aligned : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (entry_valid_i && entry_i.meta.size == size_word) |-> (entry_i.meta.offset == 2'b00))
  else $error("Word load at a nonzero byte offset");

endmodule

`default_nettype wire

/* verilog/ld_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ldu_consts.svh"

module ld_unit_top import ldu_pkg::*; (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire ld_req_t                req_i,
  input  wire logic                   req_valid_i,
  output logic                        req_ready_o,
  input  wire logic                   wr_en_i,
  input  wire logic [`LDU_ADDR_W-3:0] wr_addr_i,
  input  wire logic [`LDU_DATA_W-1:0] wr_data_i,
  output ld_rsp_t                     rsp_o,
  output logic                        rsp_valid_o
);

  // Issue to ROB
  logic       rob_full;
  logic       rob_id_req;
  rob_id_t    rob_id;
  // Issue to banks
  mem_req_t   mem_req;
  logic       mem_req_valid;
  // Banks to ROB
  mem_rsp_t   mem_rsp;
  logic       mem_rsp_valid;
  rob_entry_t rob_push_data;
  // ROB to align
  rob_entry_t rob_head;
  logic       rob_head_valid;
  logic       rob_pop;

  ld_issue i_issue (
    .clk_i,
    .rst_ni,
    .req_i,
    .req_valid_i,
    .req_ready_o,
    .rob_full_i      (rob_full),
    .rob_id_req_o    (rob_id_req),
    .rob_id_i        (rob_id),
    .mem_req_o       (mem_req),
    .mem_req_valid_o (mem_req_valid)
  );

  mem_banks i_banks (
    .clk_i,
    .rst_ni,
    .mem_req_i       (mem_req),
    .mem_req_valid_i (mem_req_valid),
    .wr_en_i,
    .wr_addr_i,
    .wr_data_i,
    .mem_rsp_o       (mem_rsp),
    .mem_rsp_valid_o (mem_rsp_valid)
  );

  // Drop the ID, the slot index carries it
  assign rob_push_data = '{word: mem_rsp.word, meta: mem_rsp.meta};

  reorder_buffer #(
    .FallThrough (1'b1)
  ) i_rob (
    .clk_i,
    .rst_ni,
    .data_i   (rob_push_data),
    .id_i     (mem_rsp.id),
    .push_i   (mem_rsp_valid),
    .data_o   (rob_head),
    .valid_o  (rob_head_valid),
    .pop_i    (rob_pop),
    .id_req_i (rob_id_req),
    .id_o     (rob_id),
    .full_o   (rob_full)
  );

  ld_align i_align (
    .clk_i,
    .rst_ni,
    .entry_i       (rob_head),
    .entry_valid_i (rob_head_valid),
    .pop_o         (rob_pop),
    .rsp_o,
    .rsp_valid_o
  );

endmodule

`default_nettype wire

/* tb/tb_ld_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ldu_consts.svh"

module tb_ld_unit import ldu_pkg::*; ();

  localparam int unsigned Words = 2 ** (`LDU_ADDR_W - 2);

  logic                   clk_i;
  logic                   rst_ni;
  ld_req_t                req_i;
  logic                   req_valid_i;
  logic                   req_ready_o;
  logic                   wr_en_i;
  logic [`LDU_ADDR_W-3:0] wr_addr_i;
  logic [`LDU_DATA_W-1:0] wr_data_i;
  ld_rsp_t                rsp_o;
  logic                   rsp_valid_o;

  // Mirror of the bank contents, indexed by word address
  logic [`LDU_DATA_W-1:0] mem_model [Words];
  ld_rsp_t                exp_q [$];
  string                  test_name;
  int                     err_cnt;
  int                     acc_cnt;
  int                     rsp_cnt;
  logic                   saw_stall;
  // Counter values at the start of the current test
  int                     err_base;
  int                     acc_base;
  int                     rsp_base;

  ld_unit_top DUT (
    .clk_i,
    .rst_ni,
    .req_i,
    .req_valid_i,
    .req_ready_o,
    .wr_en_i,
    .wr_addr_i,
    .wr_data_i,
    .rsp_o,
    .rsp_valid_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Expected result straight from the byte lanes of the model word
  function automatic ld_rsp_t expected_load(logic [`LDU_ADDR_W-1:0] addr, ld_size_e size,
                                            logic sign);
    logic [`LDU_DATA_W-1:0] word;
    logic [7:0]             b;
    logic [15:0]            h;
    ld_rsp_t                r;
    word = mem_model[addr[`LDU_ADDR_W-1:2]];
    b    = word[addr[1:0]*8 +: 8];
    h    = word[addr[1]*16 +: 16];
    case (size)
      size_byte: r.data = sign ? {{24{b[7]}}, b} : {24'h0, b};
      size_half: r.data = sign ? {{16{h[15]}}, h} : {16'h0, h};
      default:   r.data = word;
    endcase
    return r;
  endfunction

  task automatic check_rsp(string name, ld_rsp_t exp, ld_rsp_t act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected %08h, actual %08h", name, exp.data, act.data);
      err_cnt++;
    end
  endtask

  task automatic check_level(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic stop_on_timeout(string what);
    $display("Timeout while %s in test %s", what, test_name);
    $display("Testbench failed");
    $finish;
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni && rsp_valid_o) begin
      rsp_cnt++;
      if (exp_q.size() == 0) begin
        $display("Response %08h arrived with no load outstanding in %s", rsp_o.data, test_name);
        err_cnt++;
      end else begin
        check_rsp(test_name, exp_q.pop_front(), rsp_o);
      end
    end
  end

  // Every stimulus task starts and ends 1 ns after a rising edge
  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic write_word(logic [`LDU_ADDR_W-3:0] waddr, logic [`LDU_DATA_W-1:0] data);
    wr_en_i   = 1'b1;
    wr_addr_i = waddr;
    wr_data_i = data;
    mem_model[waddr] = data;
    idle(1);
    wr_en_i = 1'b0;
  endtask

  // Hold the request until the DUT takes it
  task automatic issue_load(logic [`LDU_ADDR_W-1:0] addr, ld_size_e size, logic sign);
    int   cycles;
    logic taken;
    cycles      = 0;
    taken       = 1'b0;
    req_i.addr  = addr;
    req_i.size  = size;
    req_i.sign  = sign;
    req_valid_i = 1'b1;
    while (!taken) begin
      @(negedge clk_i);
      if (req_ready_o) begin
        taken = 1'b1;
        acc_cnt++;
        exp_q.push_back(expected_load(addr, size, sign));
      end else begin
        saw_stall = 1'b1;
      end
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles > 200) begin
        stop_on_timeout("waiting for req_ready_o");
      end
    end
    req_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0) begin
      idle(1);
      cycles++;
      if (cycles > 500) begin
        stop_on_timeout("waiting for outstanding loads to return");
      end
    end
    idle(2);
  endtask

  // Naturally aligned random address for a given size
  function automatic logic [`LDU_ADDR_W-1:0] rand_addr(ld_size_e size);
    logic [`LDU_ADDR_W-1:0] a;
    a = `LDU_ADDR_W'($urandom);
    if (size == size_half) a[0] = 1'b0;
    if (size == size_word) a[1:0] = 2'b00;
    return a;
  endfunction

  task automatic start_test(string name);
    test_name = name;
    err_base  = err_cnt;
    acc_base  = acc_cnt;
    rsp_base  = rsp_cnt;
  endtask

  task automatic finish_test();
    wait_drain();
    check_level({test_name, " response count"}, 1'b1,
                (rsp_cnt - rsp_base) == (acc_cnt - acc_base));
    $display("%-12s %s, %0d loads, %0d errors", test_name,
             (err_cnt == err_base) ? "ok" : "FAILED", acc_cnt - acc_base, err_cnt - err_base);
  endtask

  initial begin
    ld_size_e               sz;
    logic [`LDU_ADDR_W-1:0] addr;
    logic [`LDU_DATA_W-1:0] pat [4];
    void'($urandom(32'hd2a657b8));
    rst_ni      = 1'b0;
    req_i       = '0;
    req_valid_i = 1'b0;
    wr_en_i     = 1'b0;
    wr_addr_i   = '0;
    wr_data_i   = '0;
    err_cnt     = 0;
    acc_cnt     = 0;
    rsp_cnt     = 0;
    saw_stall   = 1'b0;
    start_test("reset");
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Ready comes up one edge after reset release
    idle(2);
    check_level("reset rsp_valid_o", 1'b0, rsp_valid_o);
    check_level("reset req_ready_o", 1'b1, req_ready_o);
    finish_test();

    // Fill all words and load from both banks
    start_test("word_loads");
    for (int w = 0; w < Words; w++) begin
      write_word(6'(w), $urandom);
    end
    for (int w = 0; w < 16; w++) begin
      issue_load({w[`LDU_ADDR_W-3:0], 2'b00}, size_word, 1'b0);
    end
    finish_test();

    // Slow then fast so the fast one finishes first in the banks
    start_test("out_of_order");
    for (int i = 0; i < 12; i++) begin
      issue_load({5'(i), (i % 2 == 0), 2'b00}, size_word, 1'b0);
    end
    finish_test();

    // Patterns with the sign bit set in various lanes
    start_test("extract");
    pat[0] = 32'h80ff7f01;
    pat[1] = 32'h7f80ff00;
    pat[2] = 32'hffff8000;
    pat[3] = 32'h00807fff;
    for (int w = 0; w < 4; w++) begin
      write_word(6'(w + 8), pat[w]);
    end
    for (int w = 0; w < 4; w++) begin
      for (int s = 0; s < 2; s++) begin
        for (int off = 0; off < 4; off++) begin
          issue_load({6'(w + 8), 2'(off)}, size_byte, s[0]);
        end
        for (int off = 0; off < 4; off += 2) begin
          issue_load({6'(w + 8), 2'(off)}, size_half, s[0]);
        end
      end
    end
    finish_test();

    // Mostly slow loads back to back so the ROB fills
    start_test("flow_control");
    saw_stall = 1'b0;
    for (int i = 0; i < 24; i++) begin
      sz   = ld_size_e'($urandom_range(0, 2));
      addr = rand_addr(sz);
      // Two loads in three go to the slow bank
      addr[2] = (i % 3 != 2);
      issue_load(addr, sz, 1'($urandom));
    end
    check_level("flow_control ready dropped", 1'b1, saw_stall);
    finish_test();

    // Random loads with writes only while the unit is idle
    start_test("random_mix");
    for (int i = 0; i < 300; i++) begin
      if ($urandom_range(0, 24) == 0) begin
        wait_drain();
        write_word(6'($urandom), $urandom);
      end
      sz = ld_size_e'($urandom_range(0, 2));
      issue_load(rand_addr(sz), sz, 1'($urandom));
      idle($urandom_range(0, 3));
    end
    finish_test();

    $display("Loads %0d, responses %0d, errors %0d", acc_cnt, rsp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
verilog/ldu_pkg.sv
verilog/ld_issue.sv
verilog/mem_banks.sv
verilog/reorder_buffer.sv
verilog/ld_align.sv
verilog/ld_unit_top.sv
tb/tb_ld_unit.sv
